// File: design/host_ring_consts.svh
/*
 * Width and sizing constants for the host ring subsystem
 * Include this header in any file that sizes a port, a type or a counter
 */

`ifndef HOST_RING_CONSTS_SVH
`define HOST_RING_CONSTS_SVH

// Width of one data line from the accelerator
`define HR_DATA_WIDTH 64

// Ring index width, so the ring has 64 slots
`define HR_IDX_WIDTH 6

// Cache-line address width on the memory channel
`define HR_ADDR_WIDTH 32

// Idle counter width; its top bit marks 16 counted idle cycles
`define HR_IDLE_BITS 5

// Memory write credits available after reset
`define HR_CREDITS 4

`endif

// File: design/host_chan_pkg.sv
/*
 * Types for the memory write channel between the ring writer,
 * the write channel arbiter and host memory
 */

`include "host_ring_consts.svh"

`default_nettype none

package host_chan_pkg;

    // Request type carried in every write header
    typedef enum logic
    {
        WR_THRU  = 1'b0,
        WR_FENCE = 1'b1
    } req_type_t;

    // Write header with the request type and the target line address
    typedef struct packed
    {
        req_type_t                 req_type;
        logic [`HR_ADDR_WIDTH-1:0] addr;
    } wr_header_t;

    // A full write request as seen by the arbiter and by memory
    typedef struct packed
    {
        logic                      valid;
        wr_header_t                hdr;
        logic [`HR_DATA_WIDTH-1:0] data;
    } wr_req_t;

    // Arbiter answer to the writer
    // can_issue says a credit is free, writer_grant says the request goes out now
    typedef struct packed
    {
        logic can_issue;
        logic writer_grant;
    } chan_grant_t;

endpackage

`default_nettype wire

// File: design/host_ring_pkg.sv
/*
 * Types for ring buffer state and host control
 * Shared by the ring writer, the status manager and the top level
 */

`include "host_ring_consts.svh"

`default_nettype none

package host_ring_pkg;

    // Index of one slot in the ring
    typedef logic [`HR_IDX_WIDTH-1:0] ring_idx_t;

    // Static control from the host
    typedef struct packed
    {
        logic                      enable;
        logic [`HR_ADDR_WIDTH-1:0] base_addr;
    } ring_ctrl_t;

    // Consumed-index update sent by the host
    typedef struct packed
    {
        logic      valid;
        ring_idx_t consumed_idx;
    } host_update_t;

    // Status the writer needs in order to detect a full ring
    typedef struct packed
    {
        ring_idx_t oldest_idx;
    } ring_status_t;

endpackage

`default_nettype wire

// File: design/line_fifo.sv
/*
 * Two-entry register FIFO for incoming lines
 * Both flags are registered and follow the occupancy of the next cycle
 */

`include "host_ring_consts.svh"

`default_nettype none

module line_fifo
#(
    parameter int N_DATA_BITS = `HR_DATA_WIDTH
)
(
    input  wire logic                   clk,
    input  wire logic                   resetb,
    input  wire logic [N_DATA_BITS-1:0] enq_data,
    input  wire logic                   enq_en,
    output logic                        not_full,
    output logic [N_DATA_BITS-1:0]      first,
    input  wire logic                   deq_en,
    output logic                        not_empty
);

    logic [N_DATA_BITS-1:0] slot [2];
    logic                   wr_ptr;
    logic                   rd_ptr;
    logic [1:0]             count;
    logic [1:0]             count_next;
    logic                   do_enq;
    logic                   do_deq;

    // Requests are honored only when the matching flag allows them
    assign do_enq = enq_en && not_full;
    assign do_deq = deq_en && not_empty;

    // The head slot is always visible to the consumer
    assign first = slot[rd_ptr];

    always_comb
    begin
        count_next = count;
        if (do_enq && !do_deq)
        begin
            count_next = count + 2'd1;
        end
        else if (!do_enq && do_deq)
        begin
            count_next = count - 2'd1;
        end
    end

    // Line storage
    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            slot[wr_ptr] <= enq_data;
        end
    end

    // Pointers, occupancy and flags
    // Ready stays low for the first cycle after reset
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            wr_ptr    <= 1'b0;
            rd_ptr    <= 1'b0;
            count     <= 2'd0;
            not_full  <= 1'b0;
            not_empty <= 1'b0;
        end
        else
        begin
            if (do_enq)
            begin
                wr_ptr <= !wr_ptr;
            end
            if (do_deq)
            begin
                rd_ptr <= !rd_ptr;
            end
            count     <= count_next;
            not_full  <= (count_next != 2'd2);
            not_empty <= (count_next != 2'd0);
        end
    end

endmodule

`default_nettype wire

// File: design/fifo_to_host.sv
/*
 * Ring writer that moves lines from the line FIFO into the host ring
 * Each line goes to base plus write index as a write-through
 * A write fence is emitted after an idle run or a quarter-ring crossing,
 * and only the fence grant publishes the new write index
 */

`include "host_ring_consts.svh"

`default_nettype none

module fifo_to_host
(
    input  wire logic                      clk,
    input  wire logic                      resetb,
    input  wire host_ring_pkg::ring_ctrl_t ctrl,
    input  wire logic [`HR_DATA_WIDTH-1:0] line_data,
    input  wire logic                      line_valid,
    output logic                           line_deq,
    input  wire host_chan_pkg::chan_grant_t grant,
    input  wire host_ring_pkg::ring_status_t status,
    output host_chan_pkg::wr_req_t         wr_req,
    output host_ring_pkg::ring_idx_t       written_idx
);

    // ======================================
    // Ring pointers
    // ======================================

    // Next slot to be written
    host_ring_pkg::ring_idx_t cur_idx;
    host_ring_pkg::ring_idx_t next_idx;

    assign next_idx = cur_idx + host_ring_pkg::ring_idx_t'(1);

    // The ring is full when the next slot would land on the host's oldest entry
    logic allow_write;
    assign allow_write = (next_idx != status.oldest_idx);

    // Bit 4 of the index toggles every quarter of the ring
    // A mismatch with the published index forces a fence
    logic flush_for_writes;
    assign flush_for_writes = (cur_idx[`HR_IDX_WIDTH-2] != written_idx[`HR_IDX_WIDTH-2]);

    // ======================================
    // Writer state
    // ======================================

    typedef enum logic [1:0]
    {
        ST_WAIT_EMPTY,
        ST_WAIT_DATA,
        ST_EMIT_FENCE
    } state_t;

    state_t state;

    // A line leaves the FIFO only when its data write is granted
    assign line_deq = grant.writer_grant && (state != ST_EMIT_FENCE);

    // Idle counter used to flush a partial run
    logic [`HR_IDLE_BITS-1:0] idle_cnt;
    logic                     flush_for_idle;

    assign flush_for_idle = idle_cnt[`HR_IDLE_BITS-1];

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            idle_cnt <= '0;
        end
        else if ((state != ST_WAIT_DATA) || line_deq)
        begin
            idle_cnt <= '0;
        end
        else if (grant.can_issue)
        begin
            // Only cycles where the channel has credit count as idle
            // A saturated channel should not trigger extra fences
            idle_cnt <= idle_cnt + `HR_IDLE_BITS'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state       <= ST_WAIT_EMPTY;
            cur_idx     <= '0;
            written_idx <= '0;
        end
        else
        begin
            case (state)
                ST_WAIT_EMPTY:
                begin
                    // First line of a new run
                    if (grant.writer_grant)
                    begin
                        state   <= ST_WAIT_DATA;
                        cur_idx <= next_idx;
                    end
                end

                ST_WAIT_DATA:
                begin
                    if (grant.writer_grant)
                    begin
                        cur_idx <= next_idx;
                    end
                    if (flush_for_idle || flush_for_writes)
                    begin
                        state <= ST_EMIT_FENCE;
                    end
                end

                ST_EMIT_FENCE:
                begin
                    // Once the fence is out the lines before cur_idx are safe
                    if (grant.writer_grant)
                    begin
                        state       <= ST_WAIT_EMPTY;
                        written_idx <= cur_idx;
                    end
                end

                default:
                begin
                    state <= ST_WAIT_EMPTY;
                end
            endcase
        end
    end

    // ======================================
    // Request generation
    // ======================================

    // Data writes need ring space, a fence only needs the enable
    always_comb
    begin
        wr_req.valid = ctrl.enable &&
                       ((state == ST_EMIT_FENCE) || (line_valid && allow_write));
        wr_req.data  = line_data;

        if (state == ST_EMIT_FENCE)
        begin
            wr_req.hdr.req_type = host_chan_pkg::WR_FENCE;
            wr_req.hdr.addr     = '0;
        end
        else
        begin
            wr_req.hdr.req_type = host_chan_pkg::WR_THRU;
            wr_req.hdr.addr     = ctrl.base_addr +
                                  {{(`HR_ADDR_WIDTH-`HR_IDX_WIDTH){1'b0}}, cur_idx};
        end
    end

endmodule

`default_nettype wire

// File: design/write_channel_arb.sv
/*
 * Credit-based arbiter for the memory write channel
 * Grants the writer while credits remain and forwards granted requests
 * to memory with valid set only on the grant cycle
 */

`include "host_ring_consts.svh"

`default_nettype none

module write_channel_arb
(
    input  wire logic                    clk,
    input  wire logic                    resetb,
    input  wire host_chan_pkg::wr_req_t  wr_req,
    input  wire logic                    mem_credit_ret,
    output host_chan_pkg::chan_grant_t   grant,
    output host_chan_pkg::wr_req_t       mem_req
);

    localparam int CREDIT_BITS = $clog2(`HR_CREDITS + 1);

    logic [CREDIT_BITS-1:0] credits;

    // Any free credit lets a request go out in the same cycle
    assign grant.can_issue    = (credits != '0);
    assign grant.writer_grant = wr_req.valid && grant.can_issue;

    // Memory sees the header and data untouched
    always_comb
    begin
        mem_req       = wr_req;
        mem_req.valid = grant.writer_grant;
    end

    // One credit leaves per grant and one returns per high cycle of
    // mem_credit_ret, and the count is clamped at the reset value
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            credits <= CREDIT_BITS'(`HR_CREDITS);
        end
        else if (grant.writer_grant && !mem_credit_ret)
        begin
            credits <= credits - CREDIT_BITS'(1);
        end
        else if (!grant.writer_grant && mem_credit_ret &&
                 (credits != CREDIT_BITS'(`HR_CREDITS)))
        begin
            credits <= credits + CREDIT_BITS'(1);
        end
    end

endmodule

`default_nettype wire

// File: design/ring_status_mgr.sv
/*
 * Status manager for the host ring
 * Keeps the host's consumed index for the writer and publishes the
 * written index with a one-cycle update pulse
 */

`default_nettype none

module ring_status_mgr
(
    input  wire logic                        clk,
    input  wire logic                        resetb,
    input  wire host_ring_pkg::host_update_t host_update,
    input  wire host_ring_pkg::ring_idx_t    written_idx,
    output host_ring_pkg::ring_status_t      status,
    output host_ring_pkg::ring_idx_t         pub_idx,
    output logic                             pub_update
);

    // Last index seen, used to spot a new publication
    host_ring_pkg::ring_idx_t last_idx;

    assign pub_idx = written_idx;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            status.oldest_idx <= '0;
            last_idx          <= '0;
            pub_update        <= 1'b0;
        end
        else
        begin
            // Host consumption frees ring slots one cycle after the update
            if (host_update.valid)
            begin
                status.oldest_idx <= host_update.consumed_idx;
            end
            last_idx   <= written_idx;
            pub_update <= (written_idx != last_idx);
        end
    end

endmodule

`default_nettype wire

// File: design/host_ring_top.sv
/*
 * Top level of the host ring subsystem
 * Accelerator lines enter on tx, writes leave on mem_req, and the host
 * sees the published index on pub_idx and pub_update
 */

`include "host_ring_consts.svh"

`default_nettype none

module host_ring_top
(
    input  wire logic                        clk,
    input  wire logic                        resetb,
    input  wire logic [`HR_DATA_WIDTH-1:0]   tx_data,
    input  wire logic                        tx_enable,
    output logic                             tx_rdy,
    input  wire host_ring_pkg::ring_ctrl_t   ctrl,
    input  wire host_ring_pkg::host_update_t host_update,
    input  wire logic                        mem_credit_ret,
    output host_chan_pkg::wr_req_t           mem_req,
    output host_ring_pkg::ring_idx_t         pub_idx,
    output logic                             pub_update
);

    // ======================================
    // Internal wiring
    // ======================================

    logic [`HR_DATA_WIDTH-1:0]   line_data;
    logic                        line_valid;
    logic                        line_deq;
    host_chan_pkg::wr_req_t      wr_req;
    host_chan_pkg::chan_grant_t  grant;
    host_ring_pkg::ring_status_t status;
    host_ring_pkg::ring_idx_t    written_idx;

    // Incoming lines wait here until the writer gets a grant
    line_fifo
    #(
        .N_DATA_BITS (`HR_DATA_WIDTH)
    )
    u_line_fifo
    (
        .clk       (clk),
        .resetb    (resetb),
        .enq_data  (tx_data),
        .enq_en    (tx_enable),
        .not_full  (tx_rdy),
        .first     (line_data),
        .deq_en    (line_deq),
        .not_empty (line_valid)
    );

    fifo_to_host u_fifo_to_host
    (
        .clk         (clk),
        .resetb      (resetb),
        .ctrl        (ctrl),
        .line_data   (line_data),
        .line_valid  (line_valid),
        .line_deq    (line_deq),
        .grant       (grant),
        .status      (status),
        .wr_req      (wr_req),
        .written_idx (written_idx)
    );

    write_channel_arb u_write_channel_arb
    (
        .clk            (clk),
        .resetb         (resetb),
        .wr_req         (wr_req),
        .mem_credit_ret (mem_credit_ret),
        .grant          (grant),
        .mem_req        (mem_req)
    );

    ring_status_mgr u_ring_status_mgr
    (
        .clk         (clk),
        .resetb      (resetb),
        .host_update (host_update),
        .written_idx (written_idx),
        .status      (status),
        .pub_idx     (pub_idx),
        .pub_update  (pub_update)
    );

endmodule

`default_nettype wire

// File: test/tb_host_ring.sv
/*
 * Directed testbench for the host ring top level
 * A memory model logs every granted request and hands credits back,
 * and each test task streams lines and checks the ring writes,
 * the fences and the published index
 */

`include "host_ring_consts.svh"

`default_nettype none

module tb_host_ring;

    // The five tests need well under 1200 cycles together
    // The limit leaves more than twice that as margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RING_SLOTS     = 1 << `HR_IDX_WIDTH;
    localparam logic [`HR_ADDR_WIDTH-1:0] RING_BASE = 32'h0004_0000;

    logic                        clk = 1'b0;
    logic                        resetb;
    logic [`HR_DATA_WIDTH-1:0]   tx_data;
    logic                        tx_enable;
    logic                        tx_rdy;
    host_ring_pkg::ring_ctrl_t   ctrl;
    host_ring_pkg::host_update_t host_update;
    logic                        mem_credit_ret = 1'b0;
    host_chan_pkg::wr_req_t      mem_req;
    host_ring_pkg::ring_idx_t    pub_idx;
    logic                        pub_update;

    // Lines in the order they were accepted on tx
    logic [`HR_DATA_WIDTH-1:0] exp_data[$];

    // Memory log, with write-throughs kept apart from fences
    logic [`HR_ADDR_WIDTH-1:0] wt_addr[$];
    logic [`HR_DATA_WIDTH-1:0] wt_data[$];
    // Number of write-throughs seen before each fence
    int                        fence_pos[$];
    host_ring_pkg::ring_idx_t  pub_log[$];

    logic [2:0] ret_pipe;
    int         owed;
    logic       hold_credits;
    int         cycle_count = 0;
    integer     seed = 32'h8f16f722;
    int         error_count = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    always #20 clk = ~clk;

    host_ring_top u_dut
    (
        .clk            (clk),
        .resetb         (resetb),
        .tx_data        (tx_data),
        .tx_enable      (tx_enable),
        .tx_rdy         (tx_rdy),
        .ctrl           (ctrl),
        .host_update    (host_update),
        .mem_credit_ret (mem_credit_ret),
        .mem_req        (mem_req),
        .pub_idx        (pub_idx),
        .pub_update     (pub_update)
    );

    // ========================================
    // Memory model and run limit
    // ========================================

    // Outputs are read at the rising edge, before the DUT registers move
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped after %0d cycles before the tests finished", cycle_count);
            $display("Checks failed");
            $finish;
        end
        else if (!resetb)
        begin
            wt_addr.delete();
            wt_data.delete();
            fence_pos.delete();
            pub_log.delete();
            ret_pipe = 3'b000;
            owed     = 0;
        end
        else
        begin
            if (mem_req.valid)
            begin
                if (mem_req.hdr.req_type == host_chan_pkg::WR_FENCE)
                begin
                    fence_pos.push_back(wt_data.size());
                end
                else
                begin
                    wt_addr.push_back(mem_req.hdr.addr);
                    wt_data.push_back(mem_req.data);
                end
            end
            if (pub_update)
            begin
                pub_log.push_back(pub_idx);
            end
            // A used credit becomes owed three edges later
            owed     = owed + int'(ret_pipe[2]) - int'(mem_credit_ret);
            ret_pipe = {ret_pipe[1:0], mem_req.valid};
        end
    end

    // Owed credits go back one per cycle unless a test holds them
    always @(negedge clk)
    begin
        mem_credit_ret = resetb && !hold_credits && (owed > 0);
    end

    // ========================================
    // Helpers
    // ========================================

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("error %s: expected 0x%h, got 0x%h", name, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        resetb    = 1'b0;
        tx_enable = 1'b0;
        repeat (4) @(negedge clk);
        resetb = 1'b1;
        exp_data.delete();
    endtask

    // Right after reset nothing is ready, valid or published
    task automatic check_reset_state();
        if (tx_rdy !== 1'b0)
        begin
            report_mismatch("tx_rdy", 64'(0), 64'(tx_rdy));
        end
        if (mem_req.valid !== 1'b0)
        begin
            report_mismatch("mem_req.valid", 64'(0), 64'(mem_req.valid));
        end
        if (pub_update !== 1'b0)
        begin
            report_mismatch("pub_update", 64'(0), 64'(pub_update));
        end
        if (pub_idx !== 6'd0)
        begin
            report_mismatch("pub_idx", 64'(0), 64'(pub_idx));
        end
    endtask

    // Offers up to n lines, one per cycle while tx_rdy is high
    task automatic stream_lines(input int n, input int limit, output int sent);
        int cycles;
        sent   = 0;
        cycles = 0;
        while (sent < n && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
            if (tx_rdy)
            begin
                tx_data   = {$random(seed), $random(seed)};
                tx_enable = 1'b1;
                exp_data.push_back(tx_data);
                sent++;
            end
            else
            begin
                tx_enable = 1'b0;
            end
        end
        @(negedge clk);
        tx_enable = 1'b0;
    endtask

    task automatic wait_for_writes(input int n, input int limit);
        int waited;
        waited = 0;
        while (wt_data.size() < n && waited < limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (wt_data.size() < n)
        begin
            report_failure($sformatf("only %0d of %0d writes reached memory", wt_data.size(), n));
        end
    endtask

    task automatic wait_for_pubs(input int n, input int limit);
        int waited;
        waited = 0;
        while (pub_log.size() < n && waited < limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (pub_log.size() < n)
        begin
            report_failure("the published index was never updated");
        end
    endtask

    // Write k holds line k at ring slot k, wrapping at the ring size
    task automatic check_writes(input int count);
        logic [`HR_ADDR_WIDTH-1:0] exp_addr;
        if (wt_data.size() < count)
        begin
            report_failure($sformatf("expected %0d writes, memory saw %0d", count, wt_data.size()));
            return;
        end
        for (int k = 0; k < count; k++)
        begin
            exp_addr = RING_BASE + `HR_ADDR_WIDTH'(k % RING_SLOTS);
            if (wt_data[k] !== exp_data[k])
            begin
                report_mismatch($sformatf("mem_req.data[%0d]", k), exp_data[k], wt_data[k]);
            end
            if (wt_addr[k] !== exp_addr)
            begin
                report_mismatch($sformatf("mem_req.hdr.addr[%0d]", k),
                                64'(exp_addr), 64'(wt_addr[k]));
            end
        end
    endtask

    // ========================================
    // Directed tests
    // ========================================

    task automatic write_order_test();
        int errs;
        int sent;
        errs = error_count;
        apply_reset();
        check_reset_state();
        stream_lines(5, 60, sent);
        wait_for_writes(5, 60);
        check_writes(5);
        end_test("test 1 write order", errs);
    endtask

    task automatic idle_fence_test();
        int errs;
        int sent;
        errs = error_count;
        apply_reset();
        stream_lines(3, 40, sent);
        wait_for_writes(3, 40);
        wait_for_pubs(1, 120);
        check_writes(3);
        if (fence_pos.size() == 0)
        begin
            report_failure("no fence was issued after the idle run");
        end
        else if (fence_pos[0] != 3)
        begin
            report_mismatch("writes before fence", 64'(3), 64'(fence_pos[0]));
        end
        if (pub_log.size() > 0 && pub_log[0] !== 6'd3)
        begin
            report_mismatch("pub_idx", 64'(3), 64'(pub_log[0]));
        end
        // The update must be a single pulse
        repeat (4) @(negedge clk);
        if (pub_log.size() != 1)
        begin
            report_failure($sformatf("pub_update was high for %0d cycles", pub_log.size()));
        end
        end_test("test 2 idle fence", errs);
    endtask

    task automatic quarter_fence_test();
        int errs;
        int sent;
        errs = error_count;
        apply_reset();
        stream_lines(20, 200, sent);
        wait_for_writes(20, 200);
        wait_for_pubs(1, 100);
        check_writes(20);
        if (fence_pos.size() == 0)
        begin
            report_failure("no fence was issued during the 20-line run");
        end
        else
        begin
            if (fence_pos[0] < 16 || fence_pos[0] >= 20)
            begin
                report_failure($sformatf("first fence came after %0d writes, not at the crossing",
                                         fence_pos[0]));
            end
            if (pub_log.size() > 0 && 64'(pub_log[0]) !== 64'(fence_pos[0]))
            begin
                report_mismatch("pub_idx", 64'(fence_pos[0]), 64'(pub_log[0]));
            end
        end
        end_test("test 3 quarter fence", errs);
    endtask

    task automatic ring_full_test();
        int errs;
        int sent;
        errs = error_count;
        apply_reset();
        // 63 slots fill the ring and two more lines wait in the FIFO
        stream_lines(66, 300, sent);
        if (sent != 65)
        begin
            report_mismatch("lines accepted", 64'(65), 64'(sent));
        end
        if (wt_data.size() != RING_SLOTS - 1)
        begin
            report_mismatch("write count", 64'(RING_SLOTS - 1), 64'(wt_data.size()));
        end
        if (tx_rdy !== 1'b0)
        begin
            report_mismatch("tx_rdy", 64'(0), 64'(tx_rdy));
        end
        // Host consumes half the ring
        host_update.valid        = 1'b1;
        host_update.consumed_idx = 6'd32;
        @(negedge clk);
        host_update = '0;
        stream_lines(1, 60, sent);
        wait_for_writes(66, 100);
        check_writes(66);
        end_test("test 4 ring full", errs);
    endtask

    task automatic backpressure_test();
        int errs;
        int sent;
        errs = error_count;
        // Ring disabled, so both FIFO slots fill and nothing reaches memory
        ctrl.enable = 1'b0;
        apply_reset();
        stream_lines(3, 40, sent);
        if (sent != 2)
        begin
            report_mismatch("lines accepted with enable low", 64'(2), 64'(sent));
        end
        if (wt_data.size() != 0 || fence_pos.size() != 0)
        begin
            report_failure("mem_req was valid while the ring was disabled");
        end
        if (tx_rdy !== 1'b0)
        begin
            report_mismatch("tx_rdy", 64'(0), 64'(tx_rdy));
        end
        ctrl.enable = 1'b1;
        stream_lines(1, 40, sent);
        wait_for_writes(3, 60);
        check_writes(3);

        // Credits withheld, four writes use them up
        hold_credits = 1'b1;
        apply_reset();
        stream_lines(4, 40, sent);
        wait_for_writes(4, 40);
        stream_lines(3, 40, sent);
        if (sent != 2)
        begin
            report_mismatch("lines accepted without credits", 64'(2), 64'(sent));
        end
        if (wt_data.size() != 4 || fence_pos.size() != 0)
        begin
            report_failure("mem_req was valid with no credits left");
        end
        if (tx_rdy !== 1'b0)
        begin
            report_mismatch("tx_rdy", 64'(0), 64'(tx_rdy));
        end
        hold_credits = 1'b0;
        stream_lines(1, 40, sent);
        wait_for_writes(7, 80);
        check_writes(7);
        end_test("test 5 back-pressure", errs);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        resetb           = 1'b0;
        tx_data          = '0;
        tx_enable        = 1'b0;
        ctrl.enable      = 1'b1;
        ctrl.base_addr   = RING_BASE;
        host_update      = '0;
        hold_credits     = 1'b0;

        write_order_test();
        idle_fence_test();
        quarter_fence_test();
        ring_full_test();
        backpressure_test();

        $display("tests %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/host_chan_pkg.sv
design/host_ring_pkg.sv
design/line_fifo.sv
design/fifo_to_host.sv
design/write_channel_arb.sv
design/ring_status_mgr.sv
design/host_ring_top.sv
test/tb_host_ring.sv

// File: Makefile
# Verilator build and run for the host ring subsystem

TOP = tb_host_ring

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module $(TOP) -f build.f

# The run fails unless the testbench printed its pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
